// File: src/givens_pkg.sv
`default_nettype none

package givens_pkg;

    // coordinate widths.
    localparam int DATA_W = 18;                   // port width.
    localparam int EXT_W  = DATA_W + 1;           // one guard bit for cordic growth.

    // micro-rotation schedule.
    localparam int NUM_ITER       = 14;           // also width of the direction word.
    localparam int ITER_PER_STAGE = 2;
    localparam int NUM_STAGES     = NUM_ITER / ITER_PER_STAGE;

    // gain compensation, K ~= 0.6072 in Q1.14.
    localparam int GAIN_W    = 15;
    localparam int GAIN_FRAC = 14;
    localparam logic signed [GAIN_W-1:0] GAIN_K = 15'sd9949;

    // input to output, rotation stages plus the gain stage.
    localparam int LATENCY = NUM_STAGES + 1;

endpackage

`default_nettype wire

// File: src/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stage_if
    import givens_pkg::*;
();

    logic                       valid;
    logic signed [EXT_W-1:0]    x0;    // lead pair.
    logic signed [EXT_W-1:0]    y0;
    logic signed [EXT_W-1:0]    x1;    // follower pair.
    logic signed [EXT_W-1:0]    y1;
    logic        [NUM_ITER-1:0] dirs;  // bit j is the decision of iteration j.

    modport src (
        output valid, x0, y0, x1, y1, dirs
    );

    modport dst (
        input valid, x0, y0, x1, y1, dirs
    );

endinterface

`default_nettype wire

// File: src/cordic_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_stage
    import givens_pkg::*;
#(
    parameter int STAGE_IDX = 0
) (
    input  wire    clk,
    input  wire    rst_n,
    stage_if.dst   up,
    stage_if.src   dn
);

    localparam int BASE = STAGE_IDX * ITER_PER_STAGE;  // first shift of this stage.

    logic signed [EXT_W-1:0]          lx0;
    logic signed [EXT_W-1:0]          ly0;
    logic signed [EXT_W-1:0]          lx1;
    logic signed [EXT_W-1:0]          ly1;
    logic        [ITER_PER_STAGE-1:0] dir;
    logic        [NUM_ITER-1:0]       dirs_nxt;

    // one micro-rotation, returns {x, y}.
    function automatic logic [2*EXT_W-1:0] micro_rot(
        input logic signed [EXT_W-1:0] x,
        input logic signed [EXT_W-1:0] y,
        input logic                    d,
        input int                      sh
    );
        logic signed [EXT_W-1:0] xs;
        logic signed [EXT_W-1:0] ys;
        xs = x >>> sh;
        ys = y >>> sh;
        if (d) begin
            return {x - ys, y + xs};  // rotate counter-clockwise.
        end
        return {x + ys, y - xs};      // rotate clockwise.
    endfunction

    always_comb begin
        lx0 = up.x0;
        ly0 = up.y0;
        lx1 = up.x1;
        ly1 = up.y1;
        for (int i = 0; i < ITER_PER_STAGE; i++) begin
            // decide from the lead pair, then apply to both pairs.
            dir[i]     = lx0[EXT_W-1] ^ ly0[EXT_W-1];
            {lx0, ly0} = micro_rot(lx0, ly0, dir[i], BASE + i);
            {lx1, ly1} = micro_rot(lx1, ly1, dir[i], BASE + i);
        end
    end

    always_comb begin
        dirs_nxt                          = up.dirs;
        dirs_nxt[BASE +: ITER_PER_STAGE] = dir;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dn.valid <= 1'b0;
            dn.x0    <= '0;
            dn.y0    <= '0;
            dn.x1    <= '0;
            dn.y1    <= '0;
            dn.dirs  <= '0;
        end else begin
            dn.valid <= up.valid;
            if (up.valid) begin
                dn.x0   <= lx0;
                dn.y0   <= ly0;
                dn.x1   <= lx1;
                dn.y1   <= ly1;
                dn.dirs <= dirs_nxt;
            end
        end
    end

    // the valid chain must stay clean through the whole pipeline.
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(dn.valid)
    ) else $error("stage %0d: valid is unknown", STAGE_IDX);

endmodule

`default_nettype wire

// File: src/gain_comp.sv
`timescale 1ns/1ps
`default_nettype none

module gain_comp
    import givens_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    stage_if.dst                       up,
    output logic                       valid_o,
    output logic signed [DATA_W-1:0]   x0_o,
    output logic signed [DATA_W-1:0]   y0_o,
    output logic signed [DATA_W-1:0]   x1_o,
    output logic signed [DATA_W-1:0]   y1_o,
    output logic        [NUM_ITER-1:0] dirs_o
);

    localparam int PROD_W = EXT_W + GAIN_W;
    localparam logic signed [PROD_W-1:0] RND_HALF = PROD_W'(1) <<< (GAIN_FRAC - 1);

    logic signed [EXT_W-1:0]  coord   [4];
    logic signed [PROD_W-1:0] prod    [4];
    logic signed [PROD_W-1:0] rounded [4];
    logic        [3:0]        fits;

    always_comb begin
        coord[0] = up.x0;
        coord[1] = up.y0;
        coord[2] = up.x1;
        coord[3] = up.y1;
        for (int k = 0; k < 4; k++) begin
            prod[k]    = coord[k] * GAIN_K;
            rounded[k] = (prod[k] + RND_HALF) >>> GAIN_FRAC;  // round half up.
            fits[k]    = (rounded[k] == $signed(rounded[k][DATA_W-1:0]));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            x0_o    <= '0;
            y0_o    <= '0;
            x1_o    <= '0;
            y1_o    <= '0;
            dirs_o  <= '0;
        end else begin
            valid_o <= up.valid;
            if (up.valid) begin
                x0_o   <= rounded[0][DATA_W-1:0];
                y0_o   <= rounded[1][DATA_W-1:0];
                x1_o   <= rounded[2][DATA_W-1:0];
                y1_o   <= rounded[3][DATA_W-1:0];
                dirs_o <= up.dirs;
            end
        end
    end

    // inputs inside the stated range must never wrap at the output.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        up.valid |-> (&fits)
    ) else $error("gain_comp: scaled result overflows %0d bits", DATA_W);

endmodule

`default_nettype wire

// File: src/givens_pe.sv
`timescale 1ns/1ps
`default_nettype none

module givens_pe
    import givens_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        valid_i,
    input  wire  signed [DATA_W-1:0]   x0_i,
    input  wire  signed [DATA_W-1:0]   y0_i,
    input  wire  signed [DATA_W-1:0]   x1_i,
    input  wire  signed [DATA_W-1:0]   y1_i,
    output logic                       valid_o,
    output logic signed [DATA_W-1:0]   x0_o,
    output logic signed [DATA_W-1:0]   y0_o,
    output logic signed [DATA_W-1:0]   x1_o,
    output logic signed [DATA_W-1:0]   y1_o,
    output logic        [NUM_ITER-1:0] dirs_o
);

    // link k feeds stage k, the last link feeds the gain stage.
    stage_if link [NUM_STAGES+1] ();

    // widen into the guard bit by sign extension.
    assign link[0].valid = valid_i;
    assign link[0].x0    = EXT_W'(x0_i);
    assign link[0].y0    = EXT_W'(y0_i);
    assign link[0].x1    = EXT_W'(x1_i);
    assign link[0].y1    = EXT_W'(y1_i);
    assign link[0].dirs  = '0;  // filled in stage by stage.

    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        cordic_stage #(
            .STAGE_IDX (k)
        ) i_cordic_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .up    (link[k]),
            .dn    (link[k+1])
        );
    end

    gain_comp i_gain_comp (
        .clk     (clk),
        .rst_n   (rst_n),
        .up      (link[NUM_STAGES]),
        .valid_o (valid_o),
        .x0_o    (x0_o),
        .y0_o    (y0_o),
        .x1_o    (x1_o),
        .y1_o    (y1_o),
        .dirs_o  (dirs_o)
    );

endmodule

`default_nettype wire

// File: verification/givens_tb.sv
`timescale 1ns/1ps
`default_nettype none

module givens_tb
    import givens_pkg::*;
();

    localparam int N_ROWS     = 40;
    localparam int N_FIXED    = 6;
    localparam int N_B2B      = 24;   // rows 0 .. N_B2B-1 go in back to back.
    localparam int WAIT_LIMIT = 100;

    typedef struct packed {
        int                  x0;
        int                  y0;
        int                  x1;
        int                  y1;
        int                  gap;    // idle cycles before the row.
        int                  ex0;
        int                  ey0;
        int                  ex1;
        int                  ey1;
        logic [NUM_ITER-1:0] edirs;
    } row_t;

    typedef struct packed {
        logic signed [DATA_W-1:0] x0;
        logic signed [DATA_W-1:0] y0;
        logic signed [DATA_W-1:0] x1;
        logic signed [DATA_W-1:0] y1;
        logic [NUM_ITER-1:0]      dirs;
    } out_t;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       valid_i;
    logic signed [DATA_W-1:0]   x0_i;
    logic signed [DATA_W-1:0]   y0_i;
    logic signed [DATA_W-1:0]   x1_i;
    logic signed [DATA_W-1:0]   y1_i;
    logic                       valid_o;
    logic signed [DATA_W-1:0]   x0_o;
    logic signed [DATA_W-1:0]   y0_o;
    logic signed [DATA_W-1:0]   x1_o;
    logic signed [DATA_W-1:0]   y1_o;
    logic        [NUM_ITER-1:0] dirs_o;

    row_t             rows [N_ROWS];
    out_t             outq [$];
    logic [LATENCY-1:0] hist = '0;   // valid_i seen at the last LATENCY negedges.
    int               inflight = 0;
    int               max_inflight = 0;
    int               errors = 0;
    int               timeouts = 0;
    int               tests_run = 0;
    int               tests_failed = 0;

    always #5 clk = ~clk;

    givens_pe i_givens_pe (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .x0_i    (x0_i),
        .y0_i    (y0_i),
        .x1_i    (x1_i),
        .y1_i    (y1_i),
        .valid_o (valid_o),
        .x0_o    (x0_o),
        .y0_o    (y0_o),
        .x1_o    (x1_o),
        .y1_o    (y1_o),
        .dirs_o  (dirs_o)
    );

    task automatic check(input logic signed [63:0] got, input logic signed [63:0] exp,
                         input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // multiply by K, round half up, keep the port width.
    function automatic int scale(input longint c);
        longint p;
        p = (c * longint'(GAIN_K) + (longint'(1) <<< (GAIN_FRAC - 1))) >>> GAIN_FRAC;
        return int'($signed(p[DATA_W-1:0]));
    endfunction

    function automatic row_t with_expected(input row_t r);
        longint x;
        longint y;
        longint u;
        longint v;
        longint xs;
        longint ys;
        longint us;
        longint vs;
        x = r.x0;
        y = r.y0;
        u = r.x1;
        v = r.y1;
        for (int j = 0; j < NUM_ITER; j++) begin
            xs = x >>> j;
            ys = y >>> j;
            us = u >>> j;
            vs = v >>> j;
            r.edirs[j] = ((x < 0) != (y < 0));  // signs differ, turn toward the axis.
            if (r.edirs[j]) begin
                x = x - ys;
                y = y + xs;
                u = u - vs;
                v = v + us;
            end else begin
                x = x + ys;
                y = y - xs;
                u = u + vs;
                v = v - us;
            end
        end
        r.ex0 = scale(x);
        r.ey0 = scale(y);
        r.ex1 = scale(u);
        r.ey1 = scale(v);
        return r;
    endfunction

    function automatic row_t make_row(input int x0, input int y0, input int x1, input int y1,
                                      input int gap);
        row_t r;
        r     = '0;
        r.x0  = x0;
        r.y0  = y0;
        r.x1  = x1;
        r.y1  = y1;
        r.gap = gap;
        return with_expected(r);
    endfunction

    // the residual after the last micro-rotation scales with the vector length.
    function automatic logic residual_ok(input out_t o);
        longint ax;
        longint ay;
        ax = o.x0;
        ay = (o.y0 < 0) ? -longint'(o.y0) : longint'(o.y0);
        return ay <= (ax >>> 13) + 4;
    endfunction

    task automatic build_rows();
        int gap;
        rows[0] = make_row(20000, 0, 1000, -3000, 0);       // on the x axis.
        rows[1] = make_row(0, 20000, -5000, 7000, 0);       // on the y axis.
        rows[2] = make_row(12000, -9000, 3000, 3000, 0);
        rows[3] = make_row(0, -20000, 100, -100, 0);
        rows[4] = make_row(32767, -32767, -32767, 32767, 0);
        rows[5] = make_row(0, 0, 1234, -4321, 0);           // zero lead vector.
        for (int i = N_FIXED; i < N_ROWS; i++) begin
            gap     = (i < N_B2B) ? 0 : int'($urandom_range(4, 1));
            rows[i] = make_row(int'($urandom_range(32767, 0)),
                               int'($urandom_range(65534, 0)) - 32767,
                               int'($urandom_range(65534, 0)) - 32767,
                               int'($urandom_range(65534, 0)) - 32767, gap);
        end
    endtask

    task automatic apply_rows(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            repeat (rows[i].gap) begin
                @(posedge clk);
                valid_i <= 1'b0;
            end
            @(posedge clk);
            valid_i <= 1'b1;
            x0_i    <= DATA_W'(rows[i].x0);
            y0_i    <= DATA_W'(rows[i].y0);
            x1_i    <= DATA_W'(rows[i].x1);
            y1_i    <= DATA_W'(rows[i].y1);
        end
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    task automatic wait_outputs(input int count);
        int t;
        t = 0;
        while (outq.size() < count && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (outq.size() < count) begin
            timeouts++;
            $display("timeout: only %0d of %0d outputs arrived within %0d cycles",
                     outq.size(), count, WAIT_LIMIT);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d mismatches", name, errors - errs_before);
        end
    endtask

    // outputs are sampled mid-cycle, away from the active edge.
    always @(negedge clk) begin
        if (inflight > max_inflight) begin
            max_inflight = inflight;
        end
        if (valid_o) begin
            inflight--;
            outq.push_back(out_t'({x0_o, y0_o, x1_o, y1_o, dirs_o}));
        end
        if (valid_i) begin
            inflight++;
        end
        check(valid_o, hist[LATENCY-1], "valid_o against valid_i delayed by the latency");
        hist = {hist[LATENCY-2:0], valid_i};
    end

    initial begin
        int err0;
        void'($urandom(32'hdec7));
        rst_n   = 1'b0;
        valid_i = 1'b0;
        x0_i    = '0;
        y0_i    = '0;
        x1_i    = '0;
        y1_i    = '0;
        build_rows();

        err0 = errors;
        repeat (8) begin
            @(negedge clk);
            check(valid_o, 1'b0, "valid_o during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check(valid_o, 1'b0, "valid_o after reset before the first input");
        end
        report_test("reset", err0);

        err0 = errors;
        apply_rows(0, N_B2B - 1);
        wait_outputs(N_B2B);
        check(outq.size(), N_B2B, "outputs after back-to-back rows");
        check(max_inflight, LATENCY, "samples in flight during back-to-back input");
        report_test("latency and streaming", err0);

        err0 = errors;
        apply_rows(N_B2B, N_ROWS - 1);
        wait_outputs(N_ROWS);
        repeat (2 * LATENCY) @(negedge clk);   // no extra outputs may follow.
        check(outq.size(), N_ROWS, "outputs after rows with gaps");
        report_test("gaps", err0);

        err0 = errors;
        for (int i = 0; i < N_ROWS && i < outq.size(); i++) begin
            check(outq[i].x0, rows[i].ex0, $sformatf("row %0d x0_o", i));
            check(outq[i].y0, rows[i].ey0, $sformatf("row %0d y0_o", i));
            check(outq[i].dirs, rows[i].edirs, $sformatf("row %0d dirs_o", i));
            check(residual_ok(outq[i]), 1'b1, $sformatf("row %0d y0_o residual bound", i));
        end
        report_test("vectoring", err0);

        err0 = errors;
        for (int i = 0; i < N_ROWS && i < outq.size(); i++) begin
            check(outq[i].x1, rows[i].ex1, $sformatf("row %0d x1_o", i));
            check(outq[i].y1, rows[i].ey1, $sformatf("row %0d y1_o", i));
        end
        report_test("follower rotation", err0);

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches, %0d timeouts",
                 tests_run, tests_run - tests_failed, tests_failed, errors, timeouts);
        if (tests_failed == 0 && errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/givens_pkg.sv
src/stage_if.sv
src/cordic_stage.sv
src/gain_comp.sv
src/givens_pe.sv
verification/givens_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the givens_pe testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module givens_tb

status=0
./obj_dir/Vgivens_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Regression passed" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
